/* hw/ddr_macros.svh */
`ifndef DDR_MACROS_SVH
`define DDR_MACROS_SVH

// scl stall lengths for the closing patterns
`define DDR_STALL_W        4
`define DDR_RESTART_STALL  4'd8
`define DDR_EXIT_STALL     4'd11

// register file map
`define DDR_REGF_AW        10
`define DDR_WR_BASE        10'd1     // regular write data
`define DDR_RD_BASE        10'd10    // regular read data
`define DDR_IMM_BASE       10'd20    // immediate write data
`define DDR_FILL_ADDR      10'd1000  // parked here after the last byte

// target addressing, index 0 lands on the broadcast address
`define DDR_DEV_IDX_W      5
`define DDR_TGT_ADDR_W     7
`define DDR_ADDR_OFFSET    7'd8

`endif

/* hw/ddr_pkg.sv */
package ddr_pkg;

  // controller states in frame order
  typedef enum logic [4:0] {
    ST_IDLE        = 5'd0,
    ST_CMD_PRE     = 5'd1,   // special command preamble
    ST_RW_BIT      = 5'd2,
    ST_SEVEN_ZEROS = 5'd3,
    ST_ADDR        = 5'd4,
    ST_PARITY      = 5'd5,   // command or data parity
    ST_WR_PRE      = 5'd6,
    ST_ACK_WAIT    = 5'd7,
    ST_BYTE1       = 5'd8,
    ST_BYTE2       = 5'd9,
    ST_FILL_ZEROS  = 5'd10,  // pads an odd final byte
    ST_DATA_PRE    = 5'd11,
    ST_ABORT       = 5'd12,
    ST_CRC_PRE1    = 5'd13,
    ST_CRC_PRE2    = 5'd14,
    ST_CRC_TOKEN   = 5'd15,
    ST_CRC_VALUE   = 5'd16,
    ST_ERROR       = 5'd17,
    ST_RESTART     = 5'd18,
    ST_EXIT        = 5'd19
  } ddr_state_e;

  // transmit engine modes
  typedef enum logic [3:0] {
    TX_SEVEN_ZEROS = 4'd0,
    TX_ADDR        = 4'd1,
    TX_SPECIAL_PRE = 4'd2,
    TX_ONE         = 4'd3,
    TX_ZERO        = 4'd4,
    TX_BYTE        = 4'd5,
    TX_PARITY      = 4'd6,
    TX_CRC_VALUE   = 4'd7,
    TX_CRC_TOKEN   = 4'd8,
    TX_RESTART     = 4'd9,
    TX_EXIT        = 4'd10
  } ddr_tx_mode_e;

  // receive engine modes
  typedef enum logic [3:0] {
    RX_PREAMBLE = 4'd0,
    RX_BYTE     = 4'd3,
    RX_TOKEN    = 4'd4,
    RX_PARITY   = 4'd5,
    RX_CRC      = 4'd6,
    RX_ERROR    = 4'd7
  } ddr_rx_mode_e;

  // error codes reported to the register file
  typedef enum logic [3:0] {
    ERR_SUCCESS     = 4'd0,
    ERR_CRC         = 4'd1,
    ERR_PARITY      = 4'd2,
    ERR_FRAME       = 4'd3,
    ERR_NACK        = 4'd5,
    ERR_SHORT_READ  = 4'd7,
    ERR_BUS_ABORTED = 4'd9
  } ddr_err_e;

endpackage

/* hw/ddr_fsm.sv */
`timescale 1ns/1ps

module ddr_fsm
  import ddr_pkg::*;
(
  input  logic       i_sys_clk,
  input  logic       i_sys_rst,
  input  logic       i_engine_en,        // kicks off one transfer
  input  logic       i_tx_mode_done,
  input  logic       i_rx_mode_done,
  input  logic       i_rx_pre,           // sampled preamble or ack bit
  input  logic       i_rx_error,         // parity, token or crc check failed
  input  logic       i_frmcnt_last,      // current byte is the final one
  input  logic       i_regf_wr_rd_bit,   // high for read
  input  logic       i_regf_short_read,  // short read counts as an error
  input  logic       i_regf_toc,         // high for exit, low for restart
  output ddr_state_e o_state,
  output logic       o_ack_armed,
  output logic       o_data_parity
);

  ddr_state_e next_state;
  ddr_state_e term_state;  // closing pattern picked by toc
  logic       mode_done;   // whichever engine owns the state finished
  logic       rd;

  assign mode_done  = i_tx_mode_done | i_rx_mode_done;
  assign term_state = i_regf_toc ? ST_EXIT : ST_RESTART;
  assign rd         = i_regf_wr_rd_bit;

  always_comb
  begin
    next_state = o_state;  // hold until the mode reports done
    case (o_state)
      ST_IDLE:
        if (i_engine_en)
          next_state = ST_CMD_PRE;
      ST_CMD_PRE:
        if (i_tx_mode_done)
          next_state = ST_RW_BIT;
      ST_RW_BIT:
        if (i_tx_mode_done)
          next_state = ST_SEVEN_ZEROS;
      ST_SEVEN_ZEROS:
        if (i_tx_mode_done)
          next_state = ST_ADDR;
      ST_ADDR:
        if (i_tx_mode_done)
          next_state = ST_PARITY;
      ST_PARITY:
        if (mode_done)
        begin
          if (!o_data_parity)
            next_state = rd ? ST_DATA_PRE : ST_WR_PRE;  // end of command word
          else if (rd)
            next_state = i_rx_error ? ST_ERROR : ST_DATA_PRE;
          else
            next_state = i_frmcnt_last ? ST_CRC_PRE1 : ST_DATA_PRE;
        end
      ST_WR_PRE:
        if (i_tx_mode_done)
          next_state = ST_ACK_WAIT;
      ST_ACK_WAIT:
        if (i_rx_mode_done)
          next_state = i_rx_pre ? ST_ERROR : ST_BYTE1;  // high bit is a nack
      ST_BYTE1:
        if (mode_done)
          next_state = i_frmcnt_last ? ST_FILL_ZEROS : ST_BYTE2;
      ST_BYTE2, ST_FILL_ZEROS:
        if (mode_done)
          next_state = ST_PARITY;
      ST_DATA_PRE:
        if (mode_done)
        begin
          if (!rd || i_rx_pre)
            next_state = ST_ABORT;  // more data announced
          else if (!i_frmcnt_last && i_regf_short_read)
            next_state = ST_ERROR;  // target ended early
          else
            next_state = ST_CRC_PRE2;
        end
      ST_ABORT:
        if (mode_done)
        begin
          if (rd)
            next_state = i_frmcnt_last ? ST_ERROR : ST_BYTE1;  // controller stops overrun
          else
            next_state = i_rx_pre ? ST_BYTE1 : ST_ERROR;
        end
      ST_CRC_PRE1:
        if (mode_done)
          next_state = ST_CRC_PRE2;
      ST_CRC_PRE2:
        if (mode_done)
          next_state = (rd && !i_rx_pre) ? ST_ERROR : ST_CRC_TOKEN;
      ST_CRC_TOKEN:
        if (mode_done)
          next_state = (rd && i_rx_error) ? ST_ERROR : ST_CRC_VALUE;
      ST_CRC_VALUE:
        if (mode_done)
          next_state = (rd && i_rx_error) ? ST_ERROR : term_state;
      ST_ERROR:
        if (i_rx_mode_done)
          next_state = term_state;
      ST_RESTART, ST_EXIT:
        if (i_tx_mode_done)
          next_state = ST_IDLE;
      default:
        next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      o_state       <= ST_IDLE;
      o_ack_armed   <= 1'b0;
      o_data_parity <= 1'b0;
    end
    else
    begin
      o_state     <= next_state;
      // one idle cycle in ack wait before the receiver listens
      o_ack_armed <= (o_state == ST_ACK_WAIT) && (next_state == ST_ACK_WAIT);
      if (o_state == ST_ADDR)
        o_data_parity <= 1'b0;  // next parity closes the command word
      else if ((o_state == ST_BYTE2) || (o_state == ST_FILL_ZEROS))
        o_data_parity <= 1'b1;
    end
  end

  a_state_legal: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_state <= ST_EXIT);

endmodule

/* hw/ddr_lane_decoder.sv */
`timescale 1ns/1ps
`include "ddr_macros.svh"

module ddr_lane_decoder
  import ddr_pkg::*;
(
  input  logic                       i_sys_clk,  // sampling clock for the check below
  input  ddr_state_e                 i_state,
  input  logic                       i_ack_armed,
  input  logic                       i_data_parity,
  input  logic                       i_regf_wr_rd_bit,
  input  logic                       i_frmcnt_last,
  input  logic                       i_rx_pre,
  input  logic                       i_rx_mode_done,
  input  logic                       i_tx_mode_done,
  input  logic [`DDR_DEV_IDX_W-1:0]  i_regf_dev_index,
  output logic                       o_tx_en,
  output ddr_tx_mode_e               o_tx_mode,
  output logic [`DDR_TGT_ADDR_W-1:0] o_tx_special_data,
  output logic                       o_rx_en,
  output ddr_rx_mode_e               o_rx_mode,
  output logic                       o_frmcnt_en,
  output logic                       o_bitcnt_en,
  output logic                       o_bitcnt_rst,
  output logic [`DDR_STALL_W-1:0]    o_sclstall_no_of_cycles,
  output logic                       o_engine_done
);

  logic rd;

  assign rd = i_regf_wr_rd_bit;
  // broadcast address for index 0, direct targets follow it
  assign o_tx_special_data = {{(`DDR_TGT_ADDR_W-`DDR_DEV_IDX_W){1'b0}}, i_regf_dev_index}
                             + `DDR_ADDR_OFFSET;

  always_comb
  begin
    o_tx_en                 = 1'b0;
    o_tx_mode               = TX_SEVEN_ZEROS;
    o_rx_en                 = 1'b0;
    o_rx_mode               = RX_PREAMBLE;
    o_frmcnt_en             = 1'b1;
    o_bitcnt_en             = 1'b1;
    o_bitcnt_rst            = 1'b0;
    o_sclstall_no_of_cycles = '0;
    o_engine_done           = 1'b0;
    case (i_state)
      ST_IDLE:
      begin
        o_frmcnt_en = 1'b0;
        o_bitcnt_en = 1'b0;
      end
      ST_CMD_PRE, ST_RW_BIT, ST_SEVEN_ZEROS:
      begin
        o_tx_en     = 1'b1;
        o_frmcnt_en = 1'b0;  // frames count from the address on
        if (i_state == ST_CMD_PRE)
          o_tx_mode = TX_SPECIAL_PRE;
        else if (i_state == ST_RW_BIT)
          o_tx_mode = rd ? TX_ONE : TX_ZERO;
      end
      ST_ADDR:
      begin
        o_tx_en   = 1'b1;
        o_tx_mode = TX_ADDR;
      end
      ST_PARITY:
      begin
        o_tx_en   = !(rd && i_data_parity);  // read data parity comes from the target
        o_rx_en   = rd && i_data_parity;
        o_tx_mode = TX_PARITY;
        o_rx_mode = RX_PARITY;
      end
      ST_WR_PRE:
      begin
        o_tx_en   = 1'b1;
        o_tx_mode = TX_ONE;
      end
      ST_ACK_WAIT:
      begin
        o_rx_en   = i_ack_armed;
        // ack seen, get the first byte moving right away
        o_tx_en   = i_ack_armed && i_rx_mode_done && !i_rx_pre;
        o_tx_mode = TX_BYTE;
      end
      ST_BYTE1, ST_BYTE2, ST_FILL_ZEROS:
      begin
        o_tx_en   = !rd;
        o_rx_en   = rd;
        o_tx_mode = TX_BYTE;  // filler is a byte of zeros
        o_rx_mode = RX_BYTE;
      end
      ST_DATA_PRE, ST_CRC_PRE2:
      begin
        o_tx_en   = !rd;
        o_rx_en   = rd;
        o_tx_mode = TX_ONE;
      end
      ST_ABORT:
      begin
        o_tx_en   = rd;   // controller owns the abort bit on reads
        o_rx_en   = !rd;
        o_tx_mode = i_frmcnt_last ? TX_ZERO : TX_ONE;
      end
      ST_CRC_PRE1:
      begin
        o_tx_en   = 1'b1;
        o_tx_mode = TX_ZERO;
      end
      ST_CRC_TOKEN, ST_CRC_VALUE:
      begin
        o_tx_en   = !rd;
        o_rx_en   = rd;
        o_tx_mode = (i_state == ST_CRC_TOKEN) ? TX_CRC_TOKEN : TX_CRC_VALUE;
        o_rx_mode = (i_state == ST_CRC_TOKEN) ? RX_TOKEN : RX_CRC;
      end
      ST_ERROR:
      begin
        o_rx_en      = 1'b1;
        o_rx_mode    = RX_ERROR;
        o_bitcnt_rst = 1'b1;
      end
      ST_RESTART, ST_EXIT:
      begin
        o_tx_en       = 1'b1;
        o_tx_mode     = (i_state == ST_EXIT) ? TX_EXIT : TX_RESTART;
        o_sclstall_no_of_cycles = (i_state == ST_EXIT) ? `DDR_EXIT_STALL : `DDR_RESTART_STALL;
        o_engine_done = i_tx_mode_done;
      end
      default: ;
    endcase
  end

  // done only while closing, and the controller is idle right after
  a_done_closes: assert property (@(posedge i_sys_clk)
    o_engine_done |-> (i_state inside {ST_RESTART, ST_EXIT}) ##1 (i_state == ST_IDLE));

endmodule

/* hw/ddr_regf_addr_gen.sv */
`timescale 1ns/1ps
`include "ddr_macros.svh"

module ddr_regf_addr_gen
  import ddr_pkg::*;
(
  input  logic                    i_sys_clk,
  input  logic                    i_sys_rst,
  input  ddr_state_e              i_state,
  input  logic                    i_tx_mode_done,
  input  logic                    i_rx_mode_done,
  input  logic                    i_rx_pre,
  input  logic                    i_frmcnt_last,
  input  logic                    i_regf_wr_rd_bit,
  input  logic                    i_regf_cmd_attr,   // high for immediate transfer
  output logic [`DDR_REGF_AW-1:0] o_regf_addr,
  output logic                    o_regf_rd_en,
  output logic                    o_regf_wr_en
);

  logic                    in_byte;
  logic                    byte_done;
  logic                    ld_wr;       // ack accepted on a write
  logic                    ld_rd;       // command parity sent on a read
  logic [`DDR_REGF_AW-1:0] start_addr;

  assign in_byte    = (i_state == ST_BYTE1) || (i_state == ST_BYTE2);
  assign byte_done  = in_byte && (i_tx_mode_done || i_rx_mode_done);
  assign ld_wr      = (i_state == ST_ACK_WAIT) && i_rx_mode_done && !i_rx_pre;
  assign ld_rd      = (i_state == ST_PARITY) && i_tx_mode_done && i_regf_wr_rd_bit;
  assign start_addr = i_regf_wr_rd_bit ? `DDR_RD_BASE :
                      (i_regf_cmd_attr ? `DDR_IMM_BASE : `DDR_WR_BASE);

  assign o_regf_rd_en = in_byte && !i_regf_wr_rd_bit;  // fetch bytes to send
  assign o_regf_wr_en = in_byte && i_regf_wr_rd_bit;   // store bytes received

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
      o_regf_addr <= '0;
    else if (ld_wr || ld_rd)
      o_regf_addr <= start_addr;
    else if (byte_done)
      o_regf_addr <= i_frmcnt_last ? `DDR_FILL_ADDR : o_regf_addr + 1'b1;
  end

  a_addr_step: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    $changed(o_regf_addr) |-> (o_regf_addr == $past(o_regf_addr) + 1'b1) ||
      (o_regf_addr inside {`DDR_WR_BASE, `DDR_RD_BASE, `DDR_IMM_BASE, `DDR_FILL_ADDR}));

endmodule

/* hw/ddr_error_tracker.sv */
`timescale 1ns/1ps

module ddr_error_tracker
  import ddr_pkg::*;
(
  input  logic       i_sys_clk,
  input  logic       i_sys_rst,
  input  logic       i_engine_en,
  input  ddr_state_e i_state,
  input  logic       i_rx_mode_done,
  input  logic       i_rx_pre,
  input  logic       i_rx_error,
  input  logic       i_frmcnt_last,
  input  logic       i_regf_wr_rd_bit,
  input  logic       i_regf_short_read,
  output ddr_err_e   o_regf_error_type,
  output logic       o_regf_abort
);

  ddr_err_e det_err;    // failure seen this cycle
  logic     det_abort;
  logic     rd;

  assign rd = i_regf_wr_rd_bit;

  always_comb
  begin
    det_err   = ERR_SUCCESS;
    det_abort = 1'b0;
    if (i_rx_mode_done)
    begin
      case (i_state)
        ST_ACK_WAIT:
          if (i_rx_pre)
            det_err = ERR_NACK;
        ST_PARITY:
          if (i_rx_error)
            det_err = ERR_PARITY;
        ST_DATA_PRE:
          if (rd && i_rx_pre && i_frmcnt_last)
            det_err = ERR_BUS_ABORTED;  // target overruns, controller aborts
          else if (rd && !i_rx_pre && !i_frmcnt_last && i_regf_short_read)
            det_err = ERR_SHORT_READ;
        ST_ABORT:
          if (!rd && !i_rx_pre)
          begin
            det_err   = ERR_BUS_ABORTED;  // target stops the write
            det_abort = 1'b1;
          end
        ST_CRC_PRE2:
          if (!i_rx_pre)
            det_err = ERR_FRAME;
        ST_CRC_TOKEN:
          if (i_rx_error)
            det_err = ERR_FRAME;
        ST_CRC_VALUE:
          if (i_rx_error)
            det_err = ERR_CRC;
        default: ;
      endcase
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      o_regf_error_type <= ERR_SUCCESS;
      o_regf_abort      <= 1'b0;
    end
    else if (i_engine_en)
    begin
      o_regf_error_type <= ERR_SUCCESS;
      o_regf_abort      <= 1'b0;
    end
    else if ((o_regf_error_type == ERR_SUCCESS) && (det_err != ERR_SUCCESS))
    begin
      o_regf_error_type <= det_err;  // first failure wins
      o_regf_abort      <= det_abort;
    end
  end

  a_err_hold: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    (!$past(i_rx_mode_done) && !$past(i_engine_en)) |-> $stable(o_regf_error_type));

endmodule

/* hw/ddr_mode.sv */
`timescale 1ns/1ps
`include "ddr_macros.svh"

module ddr_mode
  import ddr_pkg::*;
(
  input  logic                       i_sys_clk,
  input  logic                       i_sys_rst,
  input  logic                       i_engine_en,
  input  logic                       i_frmcnt_last,
  input  logic                       i_tx_mode_done,
  input  logic                       i_rx_mode_done,
  input  logic                       i_rx_pre,
  input  logic                       i_rx_error,
  input  logic                       i_regf_toc,         // low restart, high exit
  input  logic [`DDR_DEV_IDX_W-1:0]  i_regf_dev_index,   // zero means broadcast
  input  logic                       i_regf_short_read,
  input  logic                       i_regf_wr_rd_bit,   // high for read
  input  logic                       i_regf_cmd_attr,    // high for immediate
  output logic                       o_tx_en,
  output ddr_tx_mode_e               o_tx_mode,
  output logic                       o_rx_en,
  output ddr_rx_mode_e               o_rx_mode,
  output logic                       o_frmcnt_en,
  output logic                       o_bitcnt_en,
  output logic                       o_bitcnt_rst,
  output logic                       o_regf_wr_en,
  output logic                       o_regf_rd_en,
  output logic [`DDR_REGF_AW-1:0]    o_regf_addr,
  output logic [`DDR_STALL_W-1:0]    o_sclstall_no_of_cycles,
  output logic                       o_engine_done,
  output logic [`DDR_TGT_ADDR_W-1:0] o_tx_special_data,
  output logic                       o_regf_abort,
  output ddr_err_e                   o_regf_error_type
);

  ddr_state_e state;
  logic       ack_armed;
  logic       data_parity;

  ddr_fsm fsm_i (
    .i_sys_clk         (i_sys_clk),
    .i_sys_rst         (i_sys_rst),
    .i_engine_en       (i_engine_en),
    .i_tx_mode_done    (i_tx_mode_done),
    .i_rx_mode_done    (i_rx_mode_done),
    .i_rx_pre          (i_rx_pre),
    .i_rx_error        (i_rx_error),
    .i_frmcnt_last     (i_frmcnt_last),
    .i_regf_wr_rd_bit  (i_regf_wr_rd_bit),
    .i_regf_short_read (i_regf_short_read),
    .i_regf_toc        (i_regf_toc),
    .o_state           (state),
    .o_ack_armed       (ack_armed),
    .o_data_parity     (data_parity)
  );

  ddr_lane_decoder lane_dec_i (
    .i_sys_clk               (i_sys_clk),
    .i_state                 (state),
    .i_ack_armed             (ack_armed),
    .i_data_parity           (data_parity),
    .i_regf_wr_rd_bit        (i_regf_wr_rd_bit),
    .i_frmcnt_last           (i_frmcnt_last),
    .i_rx_pre                (i_rx_pre),
    .i_rx_mode_done          (i_rx_mode_done),
    .i_tx_mode_done          (i_tx_mode_done),
    .i_regf_dev_index        (i_regf_dev_index),
    .o_tx_en                 (o_tx_en),
    .o_tx_mode               (o_tx_mode),
    .o_tx_special_data       (o_tx_special_data),
    .o_rx_en                 (o_rx_en),
    .o_rx_mode               (o_rx_mode),
    .o_frmcnt_en             (o_frmcnt_en),
    .o_bitcnt_en             (o_bitcnt_en),
    .o_bitcnt_rst            (o_bitcnt_rst),
    .o_sclstall_no_of_cycles (o_sclstall_no_of_cycles),
    .o_engine_done           (o_engine_done)
  );

  ddr_regf_addr_gen addr_gen_i (
    .i_sys_clk        (i_sys_clk),
    .i_sys_rst        (i_sys_rst),
    .i_state          (state),
    .i_tx_mode_done   (i_tx_mode_done),
    .i_rx_mode_done   (i_rx_mode_done),
    .i_rx_pre         (i_rx_pre),
    .i_frmcnt_last    (i_frmcnt_last),
    .i_regf_wr_rd_bit (i_regf_wr_rd_bit),
    .i_regf_cmd_attr  (i_regf_cmd_attr),
    .o_regf_addr      (o_regf_addr),
    .o_regf_rd_en     (o_regf_rd_en),
    .o_regf_wr_en     (o_regf_wr_en)
  );

  ddr_error_tracker err_trk_i (
    .i_sys_clk         (i_sys_clk),
    .i_sys_rst         (i_sys_rst),
    .i_engine_en       (i_engine_en),
    .i_state           (state),
    .i_rx_mode_done    (i_rx_mode_done),
    .i_rx_pre          (i_rx_pre),
    .i_rx_error        (i_rx_error),
    .i_frmcnt_last     (i_frmcnt_last),
    .i_regf_wr_rd_bit  (i_regf_wr_rd_bit),
    .i_regf_short_read (i_regf_short_read),
    .o_regf_error_type (o_regf_error_type),
    .o_regf_abort      (o_regf_abort)
  );

endmodule

/* verification/ddr_mode_tb.sv */
`timescale 1ns/1ps
`include "ddr_macros.svh"

module ddr_mode_tb
  import ddr_pkg::*;
();

  localparam int NUM_XFERS  = 9;
  localparam int WORST_CYC  = 400;  // longest transfer in clock cycles plus margin
  localparam int TIMEOUT_NS = NUM_XFERS * WORST_CYC * 20 + 200;

  typedef enum int {F_NONE, F_NACK, F_CRC, F_PARITY, F_SHORT, F_ABORT} fault_e;

  typedef struct packed {
    ddr_err_e                   err;
    logic [`DDR_REGF_AW-1:0]    start;
    logic [7:0]                 strobes;
    logic [`DDR_STALL_W-1:0]    stall;
    ddr_tx_mode_e               term;
    logic [`DDR_TGT_ADDR_W-1:0] tgt;
    logic                       abort;
  } exp_t;

  logic                       i_sys_clk;
  logic                       i_sys_rst;
  logic                       i_engine_en;
  logic                       i_frmcnt_last;
  logic                       i_tx_mode_done;
  logic                       i_rx_mode_done;
  logic                       i_rx_pre;
  logic                       i_rx_error;
  logic                       i_regf_toc;
  logic [`DDR_DEV_IDX_W-1:0]  i_regf_dev_index;
  logic                       i_regf_short_read;
  logic                       i_regf_wr_rd_bit;
  logic                       i_regf_cmd_attr;
  logic                       o_tx_en;
  ddr_tx_mode_e               o_tx_mode;
  logic                       o_rx_en;
  ddr_rx_mode_e               o_rx_mode;
  logic                       o_frmcnt_en;
  logic                       o_bitcnt_en;
  logic                       o_bitcnt_rst;
  logic                       o_regf_wr_en;
  logic                       o_regf_rd_en;
  logic [`DDR_REGF_AW-1:0]    o_regf_addr;
  logic [`DDR_STALL_W-1:0]    o_sclstall_no_of_cycles;
  logic                       o_engine_done;
  logic [`DDR_TGT_ADDR_W-1:0] o_tx_special_data;
  logic                       o_regf_abort;
  ddr_err_e                   o_regf_error_type;

  logic [31:0]  lfsr_q = 32'd79229;
  int           nerr = 0;
  int           nchecks = 0;
  exp_t         exp_r;
  fault_e       fault;
  int           nbytes;
  int           bytes_sent;  // bytes moved so far by the engine model
  int           nstrobe;
  int           ndone;
  ddr_tx_mode_e txq[$];      // tx modes in completion order
  ddr_state_e   eng_st;
  logic         eng_rx;
  logic         eng_last;
  logic         eng_pre;
  logic         eng_err;
  int           eng_wait;

  ddr_mode dut_i (.*);

  always #10 i_sys_clk = ~i_sys_clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 32'hA300_0000;  // galois taps 32,30,26,25
    return n;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
  endfunction

  // expected outcome of one transfer from the protocol rules
  function automatic exp_t ref_transfer(input logic rd, input int n, input logic attr,
                                        input logic toc, input logic [4:0] idx,
                                        input fault_e f);
    exp_t e;
    e.err     = ERR_SUCCESS;
    e.start   = rd ? 10'd10 : (attr ? 10'd20 : 10'd1);
    e.strobes = n[7:0];
    e.stall   = toc ? 4'd11 : 4'd8;
    e.term    = toc ? TX_EXIT : TX_RESTART;
    e.tgt     = {2'b00, idx} + 7'd8;
    e.abort   = 1'b0;
    case (f)
      F_NACK:
      begin
        e.err     = ERR_NACK;
        e.strobes = 8'd0;
      end
      F_CRC:    e.err = ERR_CRC;
      F_PARITY:
      begin
        e.err     = ERR_PARITY;
        e.strobes = (n < 2) ? n[7:0] : 8'd2;
      end
      F_SHORT:
      begin
        e.err     = ERR_SHORT_READ;
        e.strobes = 8'd2;  // stops after one pair
      end
      F_ABORT:
      begin
        e.err     = ERR_BUS_ABORTED;
        e.strobes = 8'd2;
        e.abort   = 1'b1;
      end
      default: ;
    endcase
    return e;
  endfunction

  // command word modes followed by the write preamble
  function automatic ddr_tx_mode_e cmd_mode_at(input logic rd, input int i);
    case (i)
      0:       return TX_SPECIAL_PRE;
      1:       return rd ? TX_ONE : TX_ZERO;
      2:       return TX_SEVEN_ZEROS;
      3:       return TX_ADDR;
      4:       return TX_PARITY;
      default: return TX_ONE;
    endcase
  endfunction

  // receiver setting the frame calls for in each listening slot
  function automatic ddr_rx_mode_e rx_mode_for_state(input ddr_state_e st);
    case (st)
      ST_BYTE1, ST_BYTE2, ST_FILL_ZEROS: return RX_BYTE;
      ST_PARITY:                         return RX_PARITY;
      ST_CRC_TOKEN:                      return RX_TOKEN;
      ST_CRC_VALUE:                      return RX_CRC;
      ST_ERROR:                          return RX_ERROR;
      default:                           return RX_PREAMBLE;
    endcase
  endfunction

  task automatic check_err(input ddr_err_e got, input ddr_err_e exp, input string what);
    nchecks++;
    if (got !== exp)
    begin
      nerr++;
      $display("** Error @ %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_tx_mode(input ddr_tx_mode_e got, input ddr_tx_mode_e exp,
                               input string what);
    nchecks++;
    if (got !== exp)
    begin
      nerr++;
      $display("** Error @ %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_rx_mode(input ddr_rx_mode_e got, input ddr_rx_mode_e exp,
                               input string what);
    nchecks++;
    if (got !== exp)
    begin
      nerr++;
      $display("** Error @ %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_addr(input logic [`DDR_REGF_AW-1:0] got,
                            input logic [`DDR_REGF_AW-1:0] exp);
    nchecks++;
    if (got !== exp)
    begin
      nerr++;
      $display("** Error @ %0t: regf address %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    nchecks++;
    if (got != exp)
    begin
      nerr++;
      $display("** Error @ %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // tx/rx engine and frame counter models answer each enabled mode
  always
  begin
    @(negedge i_sys_clk);
    if (i_sys_rst && (o_tx_en || o_rx_en))
    begin
      eng_st   = dut_i.state;
      eng_rx   = o_rx_en;
      if (eng_rx)
      begin
        check_rx_mode(o_rx_mode, rx_mode_for_state(eng_st), "rx mode");
        check_count(int'(o_bitcnt_rst), int'(eng_st == ST_ERROR), "bit counter reset");
      end
      eng_wait = 1 + rand_bits(2);  // done lands 2 to 5 cycles in
      repeat (eng_wait) @(posedge i_sys_clk);
      if ((eng_st == ST_BYTE1) || (eng_st == ST_BYTE2))
      begin
        eng_last = (bytes_sent + 1 == nbytes);
        bytes_sent++;
      end
      else
        eng_last = (bytes_sent >= nbytes);
      eng_pre = 1'b0;
      eng_err = 1'b0;
      case (eng_st)
        ST_ACK_WAIT:  eng_pre = (fault == F_NACK);
        ST_DATA_PRE:  eng_pre = (bytes_sent < nbytes) && !(fault == F_SHORT && bytes_sent >= 2);
        ST_ABORT:     eng_pre = !(fault == F_ABORT && bytes_sent >= 2);  // target continue bit
        ST_CRC_PRE2:  eng_pre = 1'b1;
        ST_PARITY:    eng_err = eng_rx && (fault == F_PARITY);
        ST_CRC_VALUE: eng_err = eng_rx && (fault == F_CRC);
        default: ;
      endcase
      i_frmcnt_last <= eng_last;
      i_rx_pre      <= eng_pre;
      i_rx_error    <= eng_err;
      if (eng_rx)
        i_rx_mode_done <= 1'b1;
      else
        i_tx_mode_done <= 1'b1;
      @(posedge i_sys_clk);
      i_tx_mode_done <= 1'b0;
      i_rx_mode_done <= 1'b0;
      i_rx_pre       <= 1'b0;
      i_rx_error     <= 1'b0;
    end
  end

  // compare process samples between edges
  always @(negedge i_sys_clk)
  begin
    if (i_sys_rst)
    begin
      if (i_tx_mode_done && o_tx_en)
        txq.push_back(o_tx_mode);
      if (o_tx_en && (o_tx_mode == TX_ADDR))
        check_count(int'(o_tx_special_data), int'(exp_r.tgt), "target address");
      if ((o_regf_rd_en && i_tx_mode_done) || (o_regf_wr_en && i_rx_mode_done))
      begin
        check_addr(o_regf_addr, exp_r.start + nstrobe[`DDR_REGF_AW-1:0]);
        nstrobe++;
      end
      if (o_engine_done)
      begin
        ndone++;
        check_tx_mode(o_tx_mode, exp_r.term, "closing pattern");
        check_count(int'(o_sclstall_no_of_cycles), int'(exp_r.stall), "stall cycles");
        check_count(nstrobe, int'(exp_r.strobes), "regf byte strobes");
        check_err(o_regf_error_type, exp_r.err, "error type");
        check_count(int'(o_regf_abort), int'(exp_r.abort), "abort flag");
      end
    end
  end

  task automatic run_transfer(input logic rd, input int n, input logic attr, input logic toc,
                              input fault_e f);
    logic [4:0] idx;
    idx        = 5'(rand_bits(5));
    nbytes     = n;
    fault      = f;
    bytes_sent = 0;
    nstrobe    = 0;
    ndone      = 0;
    txq.delete();
    exp_r = ref_transfer(rd, n, attr, toc, idx, f);
    @(posedge i_sys_clk);
    i_regf_wr_rd_bit  <= rd;
    i_regf_cmd_attr   <= attr;
    i_regf_toc        <= toc;
    i_regf_dev_index  <= idx;
    i_regf_short_read <= (f == F_SHORT);
    i_frmcnt_last     <= 1'b0;
    i_engine_en       <= 1'b1;
    @(posedge i_sys_clk);
    i_engine_en <= 1'b0;
    @(negedge i_sys_clk);
    while (!o_engine_done)
      @(negedge i_sys_clk);
    repeat (3) @(negedge i_sys_clk);
    check_count(ndone, 1, "engine_done pulses");
    // back in idle every enable and strobe is low
    check_count(int'({o_tx_en, o_rx_en, o_frmcnt_en, o_bitcnt_en,
                      o_regf_wr_en, o_regf_rd_en, o_engine_done}), 0, "idle enables");
    if (txq.size() < (rd ? 5 : 6))
      check_count(txq.size(), rd ? 5 : 6, "command tx modes");
    else
      for (int i = 0; i < (rd ? 5 : 6); i++)
        check_tx_mode(txq[i], cmd_mode_at(rd, i), "command tx mode");
  endtask

  initial
  begin
    i_sys_clk         = 1'b0;
    i_sys_rst         = 1'b0;
    i_engine_en       = 1'b0;
    i_frmcnt_last     = 1'b0;
    i_tx_mode_done    = 1'b0;
    i_rx_mode_done    = 1'b0;
    i_rx_pre          = 1'b0;
    i_rx_error        = 1'b0;
    i_regf_toc        = 1'b0;
    i_regf_dev_index  = '0;
    i_regf_short_read = 1'b0;
    i_regf_wr_rd_bit  = 1'b0;
    i_regf_cmd_attr   = 1'b0;
    repeat (5) @(posedge i_sys_clk);
    i_sys_rst <= 1'b1;
    repeat (2) @(posedge i_sys_clk);
    run_transfer(1'b0, 4, 1'b0, 1'b0, F_NONE);    // regular write with restart
    run_transfer(1'b0, 5, 1'b1, 1'b1, F_NONE);    // immediate write of odd count with exit
    run_transfer(1'b1, 4, 1'b0, 1'b1, F_NONE);
    run_transfer(1'b1, 3, 1'b0, 1'b0, F_NONE);    // read with filler byte
    run_transfer(1'b0, 2, 1'b0, 1'b1, F_NACK);
    run_transfer(1'b1, 2, 1'b0, 1'b0, F_CRC);
    run_transfer(1'b1, 4, 1'b0, 1'b1, F_PARITY);
    run_transfer(1'b1, 6, 1'b0, 1'b0, F_SHORT);
    run_transfer(1'b0, 5, 1'b0, 1'b1, F_ABORT);
    $display("checks run: %0d, errors: %0d", nchecks, nerr);
    if (nerr == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  // watchdog sized from the transfer count
  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: transfer never reached engine_done, %0d errors so far", nerr);
    $display("Verification failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hw
hw/ddr_pkg.sv
hw/ddr_fsm.sv
hw/ddr_lane_decoder.sv
hw/ddr_regf_addr_gen.sv
hw/ddr_error_tracker.sv
hw/ddr_mode.sv
verification/ddr_mode_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module ddr_mode_tb -f vlog.f --Mdir obj_dir -o ddr_mode_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out="$(./obj_dir/ddr_mode_sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1
